// ==== all.f ====
hw/rotPkg.sv
hw/boothMult.sv
hw/rotSequencer.sv
hw/rotCombine.sv
hw/tiltRotator.sv
bench/tiltRotator_props.sv
bench/tiltRotatorTb.sv

// ==== bench/rotation_vectors.txt ====
// accX accY accZ sinVal cosVal expXRot expYRot
// Trig in Q2.13, expected = (sum of products) >>> 13, all hex
1234 FEDC 0100 0000 2000 00001234 FFFFFEDC
03E8 FE0C FF00 2000 0000 000001F4 000003E8
03E8 0000 7FFF 16A1 16A1 000002C3 000002C3
FC18 0000 8000 16A1 16A1 FFFFFD3C FFFFFD3C
7FFF 7FFF 1234 16A1 16A1 00000000 0000B506
8000 8000 C000 0000 2000 FFFF8000 FFFF8000
8000 8000 0000 E000 0000 FFFF8000 00008000
FFFD 0007 0005 1000 1BB6 FFFFFFF9 00000004
0064 FF38 FFFB 1000 1BB6 000000BA FFFFFF84
FFFF FFFF FFFF 0001 0001 00000000 FFFFFFFF
0ABC 0123 4321 F000 1BB6 000009DD FFFFFB9D

// ==== bench/tiltRotatorTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tiltRotatorTb;

    localparam int HALF_PERIOD   = 50;
    localparam int DRIVE_DELAY   = 5;
    localparam int RESET_CYCLES  = 16;
    localparam int COLS          = 7;   // Words per vector row
    localparam int MAX_ROWS      = 64;
    localparam int DISTURB_CYCLE = 10;  // Busy cycle that gets new inputs
    localparam int SEED          = 86;

    logic            clk = 1'b0;
    logic            rst;
    logic            enable;
    rotPkg::sample_t accX;
    rotPkg::sample_t accY;
    rotPkg::sample_t accZ;
    rotPkg::trig_t   sinVal;
    rotPkg::trig_t   cosVal;
    rotPkg::axis_t   xRot;
    rotPkg::axis_t   yRot;
    rotPkg::axis_t   zRot;
    logic            busy;

    logic [31:0]     vecMem [0:MAX_ROWS*COLS-1];
    int              numRows;
    int              timeoutLimit = 100;
    int              cycleCount = 0;
    rotPkg::axis_t   prevX;     // Last result, must hold while idle
    rotPkg::axis_t   prevY;

    tiltRotator #(
        .FRAC_BITS (13)
    ) u_tiltRotator (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .accX   (accX),
        .accY   (accY),
        .accZ   (accZ),
        .sinVal (sinVal),
        .cosVal (cosVal),
        .xRot   (xRot),
        .yRot   (yRot),
        .zRot   (zRot),
        .busy   (busy)
    );

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    ////////////////////////////////////////////////
    // Helpers

    function automatic rotPkg::axis_t signExtend(input rotPkg::sample_t s);
        return {{16{s[15]}}, s};
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        #(DRIVE_DELAY);  // Outputs settled, safe to drive and sample
    endtask

    task automatic checkAxis(input string name, input rotPkg::axis_t actual,
                             input rotPkg::axis_t expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic checkLevel(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic driveRow(input int r);
        accX   = vecMem[r*COLS+0][15:0];
        accY   = vecMem[r*COLS+1][15:0];
        accZ   = vecMem[r*COLS+2][15:0];
        sinVal = vecMem[r*COLS+3][15:0];
        cosVal = vecMem[r*COLS+4][15:0];
    endtask

    ////////////////////////////////////////////////
    // One rotation

    task automatic runRow(input int r);
        int            gap;
        int            busyCycles;
        rotPkg::axis_t expX;
        rotPkg::axis_t expY;
        gap  = $urandom % 6;
        expX = vecMem[r*COLS+5];
        expY = vecMem[r*COLS+6];
        repeat (gap) begin
            stepCycle();
            checkLevel("busy", busy, 1'b0);
            checkAxis("xRot", xRot, prevX);
            checkAxis("yRot", yRot, prevY);
        end
        // Previous result still held just before the new start
        checkAxis("xRot", xRot, prevX);
        checkAxis("yRot", yRot, prevY);
        driveRow(r);
        enable = 1'b1;
        #1;
        checkAxis("zRot", zRot, signExtend(accZ));
        stepCycle();
        enable = 1'b0;
        checkLevel("busy", busy, 1'b1);
        busyCycles = 1;
        while (busy === 1'b1) begin
            stepCycle();
            enable = 1'b0;
            busyCycles++;
            if (busyCycles == 2) begin
                checkAxis("zRot", zRot, signExtend(accZ));
            end
            if (busyCycles == DISTURB_CYCLE && r % 3 == 2) begin
                // New inputs and a stray enable must not touch the snapshot
                accX   = ~accX;
                accY   = ~accY;
                accZ   = ~accZ;
                sinVal = ~sinVal;
                cosVal = ~cosVal;
                enable = 1'b1;
                #1;
                checkAxis("zRot", zRot, signExtend(accZ));
            end
        end
        checkAxis("xRot", xRot, expX);
        checkAxis("yRot", yRot, expY);
        stepCycle();
        checkLevel("busy", busy, 1'b0);  // No second busy period
        prevX = expX;
        prevY = expY;
    endtask

    ////////////////////////////////////////////////
    // Main sequence

    initial begin
        int r;
        rst    = 1'b1;
        enable = 1'b0;
        accX   = '0;
        accY   = '0;
        accZ   = '0;
        sinVal = '0;
        cosVal = '0;
        prevX  = '0;
        prevY  = '0;
        void'($urandom(SEED));
        $readmemh("bench/rotation_vectors.txt", vecMem);
        numRows = 0;
        while (numRows < MAX_ROWS && !$isunknown(vecMem[numRows*COLS])) begin
            numRows++;
        end
        if (numRows == 0) begin
            $display("No vectors could be read from bench/rotation_vectors.txt");
            $display("RESULT: FAIL");
            $fatal(1, "Empty vector file");
        end
        timeoutLimit = numRows * 85 + 100;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        checkLevel("busy", busy, 1'b0);
        checkAxis("xRot", xRot, '0);
        checkAxis("yRot", yRot, '0);

        for (r = 0; r < numRows; r++) begin
            runRow(r);
        end
        stepCycle();
        checkAxis("xRot", xRot, prevX);
        checkAxis("yRot", yRot, prevY);

        if (u_tiltRotator.u_props.failCount == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", u_tiltRotator.u_props.failCount);
            $display("RESULT: FAIL");
            $fatal(1, "Assertion failures during the run");
        end
    end

endmodule

`default_nettype wire

// ==== bench/tiltRotator_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module tiltRotator_props (
    input wire logic          clk,
    input wire logic          rst,
    input wire logic          busy,
    input wire logic          mulStart,
    input wire logic          mulBusy,
    input wire rotPkg::axis_t xRot,
    input wire rotPkg::axis_t yRot
);

    int failCount = 0;  // Read by the testbench at the end

    ////////////////////////////////////////////////
    // Operation length and multiplier protocol

    // One rotation takes 75 cycles, so 80 is a safe bound
    assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> ##[1:80] !busy)
    else begin
        failCount++;
        $error("busy stayed high longer than 80 cycles");
    end

    assert property (@(posedge clk) disable iff (rst)
        !(mulStart && mulBusy))
    else begin
        failCount++;
        $error("multiplier start raised while multiplier busy");
    end

    ////////////////////////////////////////////////
    // Held results

    assert property (@(posedge clk) disable iff (rst)
        !busy |-> ($stable(xRot) && $stable(yRot)))
    else begin
        failCount++;
        $error("xRot or yRot changed while idle");
    end

endmodule

bind tiltRotator tiltRotator_props u_props (
    .clk      (clk),
    .rst      (rst),
    .busy     (busy),
    .mulStart (mulStart),
    .mulBusy  (mulBusy),
    .xRot     (xRot),
    .yRot     (yRot)
);

`default_nettype wire

// ==== hw/boothMult.sv ====
`timescale 1ns/1ns
`default_nettype none

module boothMult (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  rotPkg::operands_t operands,
    output rotPkg::product_t  product,
    output logic              busy
);

    ////////////////////////////////////////////////
    // Datapath registers

    // One guard bit on the accumulator so that adding the
    // most negative multiplicand cannot overflow
    logic signed [16:0] acc;
    logic signed [16:0] mcand;
    logic [15:0]        mulQ;      // Multiplier, consumed LSB first
    logic               qExtra;    // Booth bit Q(-1)
    logic [3:0]         iterCount;

    logic signed [16:0] partial;
    logic signed [33:0] shifted;
    logic               accept;

    assign accept = start && !busy;

    ////////////////////////////////////////////////
    // One Booth step

    always_comb begin
        case ({mulQ[0], qExtra})
            2'b01:   partial = acc + mcand;   // End of a run of ones
            2'b10:   partial = acc - mcand;   // Start of a run of ones
            default: partial = acc;
        endcase
        // Arithmetic shift of {A, Q, Q-1} as one register
        shifted = $signed({partial, mulQ, qExtra}) >>> 1;
    end

    ////////////////////////////////////////////////
    // Iteration control

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            iterCount <= '0;
        end else if (!busy) begin
            if (start) begin
                busy      <= 1'b1;
                iterCount <= '0;
            end
        end else begin
            iterCount <= iterCount + 4'd1;
            if (iterCount == 4'd15) begin
                busy <= 1'b0;  // Sixteenth step done
            end
        end
    end

    // Operand load and shift
    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= '0;
            mcand  <= {operands.a[15], operands.a};
            mulQ   <= operands.b;
            qExtra <= 1'b0;
        end else if (busy) begin
            acc    <= shifted[33:17];
            mulQ   <= shifted[16:1];
            qExtra <= shifted[0];
        end
    end

    // Low 32 bits of {A, Q}; stays put once busy drops
    assign product = rotPkg::product_t'({acc[15:0], mulQ});

endmodule

`default_nettype wire

// ==== hw/rotCombine.sv ====
`timescale 1ns/1ns
`default_nettype none

module rotCombine #(
    parameter int FRAC_BITS = 13
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                combine,
    input  rotPkg::productSet_t products,
    output rotPkg::axis_t       xRot,
    output rotPkg::axis_t       yRot,
    output logic                done
);

    rotPkg::axis_t xSum;
    rotPkg::axis_t ySum;
    logic          sumValid;

    ////////////////////////////////////////////////
    // Stage one

    // Rotation sums still in Q.13 scale
    always_ff @(posedge clk) begin
        if (combine) begin
            xSum <= products.xCos - products.ySin;  // X*cos - Y*sin
            ySum <= products.xSin + products.yCos;  // X*sin + Y*cos
        end
    end

    ////////////////////////////////////////////////
    // Stage two

    // Truncating arithmetic shift back to sample scale
    always_ff @(posedge clk) begin
        if (rst) begin
            sumValid <= 1'b0;
            done     <= 1'b0;
            xRot     <= '0;
            yRot     <= '0;
        end else begin
            sumValid <= combine;
            done     <= sumValid;
            if (sumValid) begin
                xRot <= xSum >>> FRAC_BITS;
                yRot <= ySum >>> FRAC_BITS;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rotPkg.sv ====
`default_nettype none

package rotPkg;

    ////////////////////////////////////////////////
    // Scalar types

    // Raw accelerometer sample
    typedef logic signed [15:0] sample_t;

    // Sine or cosine in Q2.13
    typedef logic signed [15:0] trig_t;

    typedef logic signed [31:0] product_t;  // Full 16x16 product
    typedef logic signed [31:0] axis_t;     // Rotated or bypassed axis

    ////////////////////////////////////////////////
    // Grouped signals

    // Operand pair for one multiplication
    typedef struct packed {
        sample_t a;  // Multiplicand
        trig_t   b;  // Multiplier
    } operands_t;

    // All four partial products of one rotation
    typedef struct packed {
        product_t xSin;
        product_t xCos;
        product_t ySin;
        product_t yCos;
    } productSet_t;

endpackage

`default_nettype wire

// ==== hw/rotSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module rotSequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  rotPkg::sample_t     accX,
    input  rotPkg::sample_t     accY,
    input  rotPkg::trig_t       sinVal,
    input  rotPkg::trig_t       cosVal,
    input  logic                mulBusy,
    input  rotPkg::product_t    mulProduct,
    output rotPkg::operands_t   operands,
    output logic                start,
    output rotPkg::productSet_t products,
    output logic                combine,
    input  logic                done,
    output logic                busy
);

    // Capture happens on the edge that leaves stWait, in the
    // cycle the multiplier first shows busy low
    typedef enum logic [2:0] {
        stIdle,
        stIssue,
        stWait,
        stCombine,
        stFinish
    } seqState_t;

    seqState_t       state;
    logic [1:0]      prodIdx;   // 0 xSin, 1 xCos, 2 ySin, 3 yCos

    rotPkg::sample_t xSnap;
    rotPkg::sample_t ySnap;
    rotPkg::trig_t   sinSnap;
    rotPkg::trig_t   cosSnap;

    logic            accept;
    logic            captureNow;
    logic            lastProd;

    assign accept     = (state == stIdle) && enable;
    assign captureNow = (state == stWait) && !mulBusy;
    assign lastProd   = (prodIdx == 2'd3);

    ////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            prodIdx <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (enable) begin
                        state   <= stIssue;
                        prodIdx <= '0;
                    end
                end
                stIssue: begin
                    state <= stWait;   // Multiplier raises busy on this edge
                end
                stWait: begin
                    if (!mulBusy) begin
                        if (lastProd) begin
                            state <= stCombine;
                        end else begin
                            state   <= stIssue;
                            prodIdx <= prodIdx + 2'd1;
                        end
                    end
                end
                stCombine: begin
                    state <= stFinish;
                end
                stFinish: begin
                    if (done) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////
    // Input snapshot and product store

    always_ff @(posedge clk) begin
        if (accept) begin
            xSnap   <= accX;
            ySnap   <= accY;
            sinSnap <= sinVal;
            cosSnap <= cosVal;
        end
    end

    always_ff @(posedge clk) begin
        if (captureNow) begin
            case (prodIdx)
                2'd0:    products.xSin <= mulProduct;
                2'd1:    products.xCos <= mulProduct;
                2'd2:    products.ySin <= mulProduct;
                default: products.yCos <= mulProduct;
            endcase
        end
    end

    // Operand pair follows the index, steady through the wait
    always_comb begin
        case (prodIdx)
            2'd0: begin
                operands.a = xSnap;
                operands.b = sinSnap;
            end
            2'd1: begin
                operands.a = xSnap;
                operands.b = cosSnap;
            end
            2'd2: begin
                operands.a = ySnap;
                operands.b = sinSnap;
            end
            default: begin
                operands.a = ySnap;
                operands.b = cosSnap;
            end
        endcase
    end

    assign start   = (state == stIssue);    // Single cycle per product
    assign combine = (state == stCombine);
    assign busy    = (state != stIdle);

endmodule

`default_nettype wire

// ==== hw/tiltRotator.sv ====
`timescale 1ns/1ns
`default_nettype none

module tiltRotator #(
    parameter int FRAC_BITS = 13
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            enable,
    input  rotPkg::sample_t accX,
    input  rotPkg::sample_t accY,
    input  rotPkg::sample_t accZ,
    input  rotPkg::trig_t   sinVal,
    input  rotPkg::trig_t   cosVal,
    output rotPkg::axis_t   xRot,
    output rotPkg::axis_t   yRot,
    output rotPkg::axis_t   zRot,
    output logic            busy
);

    rotPkg::operands_t   mulOperands;
    logic                mulStart;
    rotPkg::product_t    mulProduct;
    logic                mulBusy;
    rotPkg::productSet_t products;
    logic                combine;
    logic                done;

    rotSequencer u_rotSequencer (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .accX       (accX),
        .accY       (accY),
        .sinVal     (sinVal),
        .cosVal     (cosVal),
        .mulBusy    (mulBusy),
        .mulProduct (mulProduct),
        .operands   (mulOperands),
        .start      (mulStart),
        .products   (products),
        .combine    (combine),
        .done       (done),
        .busy       (busy)
    );

    boothMult u_boothMult (
        .clk      (clk),
        .rst      (rst),
        .start    (mulStart),
        .operands (mulOperands),
        .product  (mulProduct),
        .busy     (mulBusy)
    );

    rotCombine #(
        .FRAC_BITS (FRAC_BITS)
    ) u_rotCombine (
        .clk      (clk),
        .rst      (rst),
        .combine  (combine),
        .products (products),
        .xRot     (xRot),
        .yRot     (yRot),
        .done     (done)
    );

    assign zRot = rotPkg::axis_t'(accZ);  // Z skips the rotation

endmodule

`default_nettype wire
